//--- rtl/bf_pkg.sv
// shared widths, beat types and the saturation helper of the two-channel beamformer
package bf_pkg;

    // one real or imaginary sample on the input and output streams
    localparam int sample_w = 16;

    // one real or imaginary part of a channel weight
    localparam int weight_w = 8;

    // complex samples carried by one beat
    localparam int SAMPLES = 8;

    // a weighted part after the fraction shift keeps two guard bits over the sample width
    localparam int acc_w = 18;

    // two weighted parts added in the combiner need one bit more
    localparam int sum_w = acc_w + 1;

    typedef logic signed [sample_w-1:0] sample_t;
    typedef logic signed [sum_w-1:0] sum_t;

    // limits of the saturated output sample
    localparam sample_t sample_max = 16'sh7fff;
    localparam sample_t sample_min = 16'sh8000;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    // sample 0 sits in the lowest 32 bits of the beat
    typedef cplx_sample_t [SAMPLES-1:0] beat_t;

    // signed fixed-point weight, the fraction point is set by frac_bits at the top level
    typedef struct packed {
        logic signed [weight_w-1:0] re;
        logic signed [weight_w-1:0] im;
    } weight_t;

    typedef struct packed {
        logic signed [acc_w-1:0] re;
        logic signed [acc_w-1:0] im;
    } acc_sample_t;

    typedef acc_sample_t [SAMPLES-1:0] acc_beat_t;

    // clamps a combined sum into the 16-bit output range
    function automatic sample_t sat16(input sum_t value);
        sample_t result;
        if (value > sample_max) begin
            result = sample_max;
        end else if (value < sample_min) begin
            result = sample_min;
        end else begin
            // inside the range the low bits already hold the two's complement value
            result = value[sample_w-1:0];
        end
        return result;
    endfunction

endpackage

//--- rtl/channel_weighter.sv
`timescale 1ns/1ps

// multiplies every complex sample of one channel's beat by the channel weight
// the result leaves two clock edges after valid was sampled
module channel_weighter #(
    parameter int frac_bits = 7
) (
    input  logic              clock,
    input  logic              resetn,
    input  logic              valid,
    input  bf_pkg::beat_t     data,
    input  bf_pkg::weight_t   weight,
    output logic              ready,
    output logic              weighted_valid,
    output bf_pkg::acc_beat_t weighted
);

    // full width of a sample by weight product
    localparam int prod_w = bf_pkg::sample_w + bf_pkg::weight_w;

    // a sum or difference of two products needs one bit more
    localparam int cross_w = prod_w + 1;

    // the four partial products of one complex multiply
    typedef struct packed {
        logic signed [prod_w-1:0] rr;
        logic signed [prod_w-1:0] ii;
        logic signed [prod_w-1:0] ri;
        logic signed [prod_w-1:0] ir;
    } prod_t;

    typedef prod_t [bf_pkg::SAMPLES-1:0] prod_beat_t;

    // weight as seen by the multipliers, one cycle behind the port
    bf_pkg::weight_t weight_q;

    // stage 1 products and their valid
    prod_beat_t prod_q;
    logic       valid_q;

    // stage 2 input, the combined and shifted parts
    bf_pkg::acc_beat_t weighted_next;

    // the weight is taken every cycle whether or not a beat arrives
    // so a new weight is in place for the beat of the following cycle
    always_ff @(posedge clock) begin
        weight_q <= weight;
    end

    // stage 1 forms rr, ii, ri and ir for each sample
    // an idle cycle loads zero so that this channel adds nothing downstream
    always_ff @(posedge clock) begin
        if (valid) begin
            for (int k = 0; k < bf_pkg::SAMPLES; k++) begin
                // operands are signed so the products are sign extended to prod_w
                prod_q[k].rr <= data[k].re * weight_q.re;
                prod_q[k].ii <= data[k].im * weight_q.im;
                prod_q[k].ri <= data[k].re * weight_q.im;
                prod_q[k].ir <= data[k].im * weight_q.re;
            end
        end else begin
            prod_q <= '0;
        end
    end

    // stage 2 combines the partial products into the complex result
    always_comb begin
        logic signed [cross_w-1:0] re_full;
        logic signed [cross_w-1:0] im_full;
        for (int k = 0; k < bf_pkg::SAMPLES; k++) begin
            // real part is xr*wr - xi*wi, imaginary part is xr*wi + xi*wr
            // the arithmetic shift drops the weight fraction and rounds toward minus infinity
            re_full = (prod_q[k].rr - prod_q[k].ii) >>> frac_bits;
            im_full = (prod_q[k].ri + prod_q[k].ir) >>> frac_bits;

            // with frac_bits matching the weight format the shifted value fits in acc_w
            weighted_next[k].re = re_full[bf_pkg::acc_w-1:0];
            weighted_next[k].im = im_full[bf_pkg::acc_w-1:0];
        end
    end

    // weighted beat register, its valid travels in the control block below
    always_ff @(posedge clock) begin
        weighted <= weighted_next;
    end

    // valid pipeline and the ready level
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_q        <= 1'b0;
            weighted_valid <= 1'b0;
            ready          <= 1'b0;
        end else begin
            valid_q        <= valid;
            weighted_valid <= valid_q;
            // there is no back-pressure, so once out of reset the channel always accepts
            ready          <= 1'b1;
        end
    end

    // a beat without its valid reaches the combiner as zero, so an idle channel adds nothing
    a_idle_beat_zero: assert property (
        @(posedge clock) disable iff (!resetn)
        !weighted_valid |-> (weighted == '0)
    );

endmodule

//--- rtl/beam_combiner.sv
`timescale 1ns/1ps

// adds the weighted beats of both channels sample by sample
// and saturates each sum back to 16 bits
module beam_combiner (
    input  logic              clock,
    input  logic              resetn,
    input  logic              valid_a,
    input  logic              valid_b,
    input  bf_pkg::acc_beat_t weighted_a,
    input  bf_pkg::acc_beat_t weighted_b,
    output logic              out_valid,
    output bf_pkg::beat_t     out_data
);

    // the beam is valid when at least one channel delivered a beat
    logic any_valid;

    // saturated sum of both channels, ready to register
    bf_pkg::beat_t sum_beat;

    assign any_valid = valid_a | valid_b;

    // a channel that was idle arrives here as zero from its weighter
    // so a plain add gives the single-channel result as well
    always_comb begin
        bf_pkg::sum_t re_sum;
        bf_pkg::sum_t im_sum;
        for (int k = 0; k < bf_pkg::SAMPLES; k++) begin
            // operands are sign extended to sum_w, so the add cannot overflow
            re_sum = weighted_a[k].re + weighted_b[k].re;
            im_sum = weighted_a[k].im + weighted_b[k].im;

            // clamp to the output range instead of wrapping
            sum_beat[k].re = bf_pkg::sat16(re_sum);
            sum_beat[k].im = bf_pkg::sat16(im_sum);
        end
    end

    // output register
    // out_data reads zero whenever no beat is being presented
    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= any_valid;
            if (any_valid) begin
                out_data <= sum_beat;
            end else begin
                out_data <= '0;
            end
        end
    end

    // a presented beat is fully resolved, even in the cycles right after reset
    a_out_data_known: assert property (
        @(posedge clock) disable iff (!resetn)
        out_valid |-> !$isunknown(out_data)
    );

endmodule

//--- rtl/beamformer_top.sv
`timescale 1ns/1ps

// two-channel complex beamformer
// each channel is weighted on its own, then both are summed into one beam
// the fixed latency from a sampled input valid to out_valid is three cycles
module beamformer_top #(
    // fraction bits of the weights, 7 makes 127 close to 1.0
    parameter int frac_bits = 7
) (
    input  logic            clock,
    input  logic            resetn,
    input  logic            valid_0,
    input  logic            valid_1,
    input  bf_pkg::beat_t   data_0,
    input  bf_pkg::beat_t   data_1,
    input  bf_pkg::weight_t weight_0,
    input  bf_pkg::weight_t weight_1,
    output logic            ready_0,
    output logic            ready_1,
    output logic            out_valid,
    output bf_pkg::beat_t   out_data
);

    // weighted beats on their way to the combiner, each with its aligned valid
    bf_pkg::acc_beat_t weighted_0;
    bf_pkg::acc_beat_t weighted_1;
    logic              weighted_valid_0;
    logic              weighted_valid_1;

    // channel 0 weighting
    channel_weighter #(
        .frac_bits (frac_bits)
    ) i_weighter_0 (
        .clock          (clock),
        .resetn         (resetn),
        .valid          (valid_0),
        .data           (data_0),
        .weight         (weight_0),
        .ready          (ready_0),
        .weighted_valid (weighted_valid_0),
        .weighted       (weighted_0)
    );

    // channel 1 weighting, same format and same latency as channel 0
    channel_weighter #(
        .frac_bits (frac_bits)
    ) i_weighter_1 (
        .clock          (clock),
        .resetn         (resetn),
        .valid          (valid_1),
        .data           (data_1),
        .weight         (weight_1),
        .ready          (ready_1),
        .weighted_valid (weighted_valid_1),
        .weighted       (weighted_1)
    );

    // both weighters have equal latency, so their beats line up here
    beam_combiner i_combiner (
        .clock      (clock),
        .resetn     (resetn),
        .valid_a    (weighted_valid_0),
        .valid_b    (weighted_valid_1),
        .weighted_a (weighted_0),
        .weighted_b (weighted_1),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

//--- test/beamformer_tb_checks.svh
`ifndef BEAMFORMER_TB_CHECKS_SVH
`define BEAMFORMER_TB_CHECKS_SVH

// compare tasks and failure helpers of the beamformer testbench

// ends the run on the first failure
task automatic stop_with_failure();
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first failure");
endtask

// failures that are not a wrong value are explained in plain words first
task automatic abort_with_reason(input string reason);
    $display("%s", reason);
    stop_with_failure();
endtask

// a wait loop ran out of cycles
task automatic report_timeout(input string what, input int cycles);
    $display("timeout: %s did not complete within %0d clock cycles", what, cycles);
    stop_with_failure();
endtask

// compares a single-bit level such as a valid or a ready
task automatic compare_level(input logic got, input logic expected, input string what);
    if (got !== expected) begin
        $display("ERR %0t: %s is %b, expected %b", $time, what, got, expected);
        stop_with_failure();
    end
endtask

// compares a whole beat and names the first sample that differs
task automatic compare_beat(
    input bf_pkg::beat_t got,
    input bf_pkg::beat_t expected,
    input string         what
);
    int first_bad;
    first_bad = 0;
    if (got !== expected) begin
        // walk down so that the lowest differing sample is reported
        for (int k = bf_pkg::SAMPLES - 1; k >= 0; k--) begin
            if (got[k] !== expected[k]) begin
                first_bad = k;
            end
        end
        $display("ERR %0t: %s sample %0d is (%0d, %0d), expected (%0d, %0d)",
                 $time, what, first_bad,
                 got[first_bad].re, got[first_bad].im,
                 expected[first_bad].re, expected[first_bad].im);
        stop_with_failure();
    end
endtask

`endif

//--- test/beamformer_tb.sv
`timescale 1ns/1ps

// testbench of the two-channel beamformer
// a table of input rows, each with its model beam, is applied one row per cycle
module beamformer_tb;

    localparam int frac_bits = 7;
    localparam int num_rows = 36;
    localparam int fixed_rows = 12;
    // the latency is three cycles, the rest is margin
    localparam int drain_timeout = 10;
    localparam int unsigned seed = 50770;

    // one row of stimulus together with the beam it should produce
    typedef struct packed {
        logic            valid_0;
        logic            valid_1;
        bf_pkg::beat_t   data_0;
        bf_pkg::beat_t   data_1;
        bf_pkg::weight_t weight_0;
        bf_pkg::weight_t weight_1;
        bf_pkg::beat_t   expected;
    } row_t;

    logic            clock = 1'b0;
    logic            resetn;
    logic            valid_0;
    logic            valid_1;
    bf_pkg::beat_t   data_0;
    bf_pkg::beat_t   data_1;
    bf_pkg::weight_t weight_0;
    bf_pkg::weight_t weight_1;
    logic            ready_0;
    logic            ready_1;
    logic            out_valid;
    bf_pkg::beat_t   out_data;

    row_t          table_rows[num_rows];
    bf_pkg::beat_t expected_q[$];

    // input valids of the last three sampling edges, bit 2 is the oldest
    logic [2:0] valid_history = 3'b0;
    logic       monitor_on = 1'b0;

    `include "beamformer_tb_checks.svh"

    beamformer_top #(
        .frac_bits (frac_bits)
    ) i_beamformer_top (
        .clock     (clock),
        .resetn    (resetn),
        .valid_0   (valid_0),
        .valid_1   (valid_1),
        .data_0    (data_0),
        .data_1    (data_1),
        .weight_0  (weight_0),
        .weight_1  (weight_1),
        .ready_0   (ready_0),
        .ready_1   (ready_1),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #10 clock = ~clock;

    // real part of x times w, scaled back by the weight fraction and kept to acc_w bits
    function automatic int scaled_real(input bf_pkg::cplx_sample_t x, input bf_pkg::weight_t w);
        int full;
        logic signed [bf_pkg::acc_w-1:0] kept;
        full = (int'(x.re) * int'(w.re) - int'(x.im) * int'(w.im)) >>> frac_bits;
        kept = full[bf_pkg::acc_w-1:0];
        return int'(kept);
    endfunction

    // imaginary part of x times w, same scaling as the real part
    function automatic int scaled_imag(input bf_pkg::cplx_sample_t x, input bf_pkg::weight_t w);
        int full;
        logic signed [bf_pkg::acc_w-1:0] kept;
        full = (int'(x.re) * int'(w.im) + int'(x.im) * int'(w.re)) >>> frac_bits;
        kept = full[bf_pkg::acc_w-1:0];
        return int'(kept);
    endfunction

    // beam of one row, an idle channel adds nothing
    function automatic bf_pkg::beat_t model_beat(input row_t r);
        bf_pkg::beat_t result;
        int re_total;
        int im_total;
        for (int k = 0; k < bf_pkg::SAMPLES; k++) begin
            re_total = 0;
            im_total = 0;
            if (r.valid_0) begin
                re_total += scaled_real(r.data_0[k], r.weight_0);
                im_total += scaled_imag(r.data_0[k], r.weight_0);
            end
            if (r.valid_1) begin
                re_total += scaled_real(r.data_1[k], r.weight_1);
                im_total += scaled_imag(r.data_1[k], r.weight_1);
            end
            result[k].re = bf_pkg::sat16(bf_pkg::sum_t'(re_total));
            result[k].im = bf_pkg::sat16(bf_pkg::sum_t'(im_total));
        end
        return result;
    endfunction

    function automatic bf_pkg::weight_t make_weight(input int re, input int im);
        bf_pkg::weight_t w;
        w.re = re[7:0];
        w.im = im[7:0];
        return w;
    endfunction

    // samples step up on the real side and down on the imaginary side
    function automatic bf_pkg::beat_t ramp_beat(input int start_re, input int start_im,
                                                input int step);
        bf_pkg::beat_t b;
        int v;
        for (int k = 0; k < bf_pkg::SAMPLES; k++) begin
            v = start_re + k * step;
            b[k].re = v[15:0];
            v = start_im - k * step;
            b[k].im = v[15:0];
        end
        return b;
    endfunction

    function automatic bf_pkg::beat_t const_beat(input int re, input int im);
        bf_pkg::beat_t b;
        for (int k = 0; k < bf_pkg::SAMPLES; k++) begin
            b[k].re = re[15:0];
            b[k].im = im[15:0];
        end
        return b;
    endfunction

    // the forced low bit keeps every random sample nonzero
    function automatic bf_pkg::beat_t random_beat();
        bf_pkg::beat_t b;
        logic [31:0] r;
        for (int k = 0; k < bf_pkg::SAMPLES; k++) begin
            r = $urandom;
            b[k].re = r[15:0] | 16'h0001;
            b[k].im = r[31:16] | 16'h0001;
        end
        return b;
    endfunction

    task automatic set_row(input int idx, input logic v0, input logic v1,
                           input bf_pkg::beat_t d0, input bf_pkg::beat_t d1,
                           input bf_pkg::weight_t w0, input bf_pkg::weight_t w1);
        table_rows[idx].valid_0  = v0;
        table_rows[idx].valid_1  = v1;
        table_rows[idx].data_0   = d0;
        table_rows[idx].data_1   = d1;
        table_rows[idx].weight_0 = w0;
        table_rows[idx].weight_1 = w1;
        table_rows[idx].expected = model_beat(table_rows[idx]);
    endtask

    task automatic fill_table();
        logic [31:0] r;
        // channel 0 alone through weight_1 zero, small negatives check the rounding
        set_row(0, 1, 1, ramp_beat(1000, -2000, 300), random_beat(),
                make_weight(64, 0), make_weight(0, 0));
        set_row(1, 1, 1, ramp_beat(-5, 7, -3), random_beat(),
                make_weight(-45, 93), make_weight(0, 0));
        set_row(2, 1, 1, ramp_beat(-12345, 23456, 1111), random_beat(),
                make_weight(100, -77), make_weight(0, 0));
        // both channels weighted and summed
        set_row(3, 1, 1, ramp_beat(500, -700, 250), ramp_beat(-3000, 1500, -400),
                make_weight(90, -20), make_weight(-60, 110));
        set_row(4, 1, 1, random_beat(), random_beat(),
                make_weight(127, 127), make_weight(-127, 5));
        // one channel idle with nonzero data, then both idle
        set_row(5, 1, 0, ramp_beat(2000, 3000, -700), random_beat(),
                make_weight(70, 30), make_weight(100, 100));
        set_row(6, 0, 1, random_beat(), ramp_beat(-8000, 100, 900),
                make_weight(120, -90), make_weight(-33, 66));
        set_row(7, 0, 0, random_beat(), random_beat(),
                make_weight(50, 50), make_weight(50, 50));
        set_row(8, 0, 0, random_beat(), random_beat(),
                make_weight(-10, 20), make_weight(30, -40));
        // full scale with weights near plus and minus one, the sums saturate
        set_row(9, 1, 1, const_beat(32767, -32768), const_beat(32767, -32768),
                make_weight(127, 0), make_weight(127, 0));
        set_row(10, 1, 1, const_beat(-32768, 32767), const_beat(-32768, -32768),
                make_weight(-127, 127), make_weight(127, -127));
        set_row(11, 1, 1, const_beat(32767, 32767), const_beat(32767, 32767),
                make_weight(127, 127), make_weight(127, 127));
        // back-to-back random rows with a new weight on every row
        for (int i = fixed_rows; i < num_rows; i++) begin
            r = $urandom;
            set_row(i, r[2:0] != 3'd0, r[5:3] != 3'd0, random_beat(), random_beat(),
                    make_weight(int'($urandom_range(0, 255)), int'($urandom_range(0, 255))),
                    make_weight(int'($urandom_range(0, 255)), int'($urandom_range(0, 255))));
        end
    endtask

    // input valids are stable at the rising edge that samples them
    always @(posedge clock) begin
        valid_history <= {valid_history[1:0], valid_0 | valid_1};
    end

    // outputs are checked at the falling edge, half a cycle after they change
    always @(negedge clock) begin
        bf_pkg::beat_t popped;
        if (monitor_on) begin
            compare_level(ready_0, 1'b1, "ready_0");
            compare_level(ready_1, 1'b1, "ready_1");
            compare_level(out_valid, valid_history[2], "out_valid");
            if (out_valid) begin
                if (expected_q.size() == 0) begin
                    abort_with_reason("out_valid was high with no beat left to expect");
                end else begin
                    popped = expected_q.pop_front();
                    compare_beat(out_data, popped, "out_data");
                end
            end else begin
                compare_beat(out_data, '0, "idle out_data");
            end
        end
    end

    initial begin
        int unsigned seed_state;
        int wait_cycles;
        seed_state = $urandom(seed);
        resetn = 1'b0;
        valid_0 = 1'b0;
        valid_1 = 1'b0;
        data_0 = '0;
        data_1 = '0;
        weight_0 = '0;
        weight_1 = '0;
        fill_table();

        // three reset cycles with all outputs quiet
        for (int c = 0; c < 3; c++) begin
            @(negedge clock);
            compare_level(ready_0, 1'b0, "ready_0 in reset");
            compare_level(ready_1, 1'b0, "ready_1 in reset");
            compare_level(out_valid, 1'b0, "out_valid in reset");
            compare_beat(out_data, '0, "out_data in reset");
        end
        resetn = 1'b1;

        // ready rises on the first edge after the release
        @(negedge clock);
        compare_level(ready_0, 1'b1, "ready_0 after reset");
        compare_level(ready_1, 1'b1, "ready_1 after reset");
        compare_level(out_valid, 1'b0, "out_valid after reset");
        compare_beat(out_data, '0, "out_data after reset");

        // the weight of row 0 goes out one cycle ahead of its data
        weight_0 = table_rows[0].weight_0;
        weight_1 = table_rows[0].weight_1;
        @(posedge clock);
        monitor_on = 1'b1;

        for (int i = 0; i < num_rows; i++) begin
            @(negedge clock);
            valid_0 = table_rows[i].valid_0;
            valid_1 = table_rows[i].valid_1;
            data_0 = table_rows[i].data_0;
            data_1 = table_rows[i].data_1;
            if (table_rows[i].valid_0 || table_rows[i].valid_1) begin
                expected_q.push_back(table_rows[i].expected);
            end
            // the next row's weight rides alongside this row's data
            if (i + 1 < num_rows) begin
                weight_0 = table_rows[i + 1].weight_0;
                weight_1 = table_rows[i + 1].weight_1;
            end
        end
        @(negedge clock);
        valid_0 = 1'b0;
        valid_1 = 1'b0;

        wait_cycles = 0;
        while (expected_q.size() != 0) begin
            @(negedge clock);
            wait_cycles++;
            if (wait_cycles > drain_timeout) begin
                report_timeout("draining the expected beats", drain_timeout);
            end
        end

        // a few idle cycles in which out_valid must stay low
        repeat (4) @(negedge clock);

        $display("Regression passed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+test
rtl/bf_pkg.sv
rtl/channel_weighter.sv
rtl/beam_combiner.sv
rtl/beamformer_top.sv
test/beamformer_tb.sv

//--- run.sh
#!/bin/sh
# builds the beamformer testbench with Verilator and runs it
# the run fails if any step fails or the log holds the fail message

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module beamformer_tb \
    -f compile.f \
    -o sim_beamformer > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_beamformer > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$sim_log"; then
    echo "failure found in $sim_log"
    exit 1
fi

if ! grep -q "Regression passed" "$sim_log"; then
    echo "no pass line in $sim_log"
    exit 1
fi

exit 0
